/* alu_pkg.sv */
// --------------------
// Shared widths, operand types and the operator encoding of the
// 64-bit integer ALU
// --------------------
package alu_pkg;

    // Datapath and word widths
    localparam int XLEN   = 64;
    localparam int WORD_W = 32;

    // Shift amount widths, full and word
    localparam int SHAMT_W      = 6;
    localparam int SHAMT_W_WORD = 5;

    // Operator code width
    localparam int OP_W = 5;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [WORD_W-1:0] word_t;

    // Operator codes, golden vectors use these in hex
    typedef enum logic [OP_W-1:0] {
        ADD  = 5'd0,
        SUB  = 5'd1,
        ADDW = 5'd2,
        SUBW = 5'd3,
        XORL = 5'd4,
        ORL  = 5'd5,
        ANDL = 5'd6,
        SRA  = 5'd7,
        SRL  = 5'd8,
        SLL  = 5'd9,
        SRAW = 5'd10,
        SRLW = 5'd11,
        SLLW = 5'd12,
        SLTS = 5'd13,
        SLTU = 5'd14,
        // Branch-only operators
        EQ   = 5'd15,
        NE   = 5'd16,
        LTS  = 5'd17,
        LTU  = 5'd18,
        GES  = 5'd19,
        GEU  = 5'd20
    } alu_op_e;

endpackage

/* alu_adder.sv */
// --------------------
// ALU adder with subtract decode and zero flag
// --------------------
`timescale 1ns/1ps

module alu_adder (
    input  alu_pkg::alu_op_e operator_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::xlen_t   operand_b_i,
    output alu_pkg::xlen_t   adder_result_o,
    output logic             adder_zero_o
);

    import alu_pkg::*;

    logic          negate_b;
    logic [XLEN:0] adder_in_a;
    logic [XLEN:0] adder_in_b;
    logic [XLEN:0] adder_sum_ext;

    // Operators that need a - b
    always_comb begin
        negate_b = 1'b0;
        case (operator_i)
            SUB, SUBW, EQ, NE: negate_b = 1'b1;
            default:           negate_b = 1'b0;
        endcase
    end

    // --------------------
    // Extended add
    // --------------------

    // Extra LSB on both sides turns the inverted b into a two's complement
    // negate: 1 + 1 carries into bit 1 only when b is inverted
    assign adder_in_a = {operand_a_i, 1'b1};
    assign adder_in_b = {operand_b_i, 1'b0} ^ {(XLEN + 1){negate_b}};

    // Carry out of bit XLEN is dropped, sum wraps
    assign adder_sum_ext = adder_in_a + adder_in_b;

    assign adder_result_o = adder_sum_ext[XLEN:1];

    // Used for EQ and NE
    assign adder_zero_o = ~|adder_result_o;

endmodule

/* alu_shifter.sv */
// --------------------
// Full-width and word shifter, left shifts done by bit reversal
// --------------------
`timescale 1ns/1ps

module alu_shifter (
    input  logic             clk_i,
    input  logic             rst_i,
    input  alu_pkg::alu_op_e operator_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::xlen_t   operand_b_i,
    output alu_pkg::xlen_t   shift_result_o,
    output alu_pkg::word_t   shift_result_word_o
);

    import alu_pkg::*;

    logic                    shift_left;
    logic                    shift_arith;
    logic                    full_op;
    logic                    word_op;
    logic [SHAMT_W-1:0]      shamt;
    logic [SHAMT_W_WORD-1:0] shamt_word;
    xlen_t                   operand_a_rev;
    word_t                   operand_a_rev_word;
    xlen_t                   shift_in;
    word_t                   shift_in_word;
    logic [XLEN:0]           shift_right;
    logic [WORD_W:0]         shift_right_word;
    xlen_t                   shift_right_rev;
    word_t                   shift_right_rev_word;

    assign shift_left  = (operator_i == SLL) || (operator_i == SLLW);
    assign shift_arith = (operator_i == SRA) || (operator_i == SRAW);
    assign full_op     = operator_i inside {SLL, SRL, SRA};
    assign word_op     = operator_i inside {SLLW, SRLW, SRAW};

    // Upper bits of operand b are ignored
    assign shamt      = operand_b_i[SHAMT_W-1:0];
    assign shamt_word = operand_b_i[SHAMT_W_WORD-1:0];

    // --------------------
    // Bit reversal
    // --------------------
    for (genvar i = 0; i < XLEN; i++) begin : g_rev_full
        assign operand_a_rev[i]   = operand_a_i[XLEN-1-i];
        assign shift_right_rev[i] = shift_right[XLEN-1-i];
    end

    for (genvar i = 0; i < WORD_W; i++) begin : g_rev_word
        assign operand_a_rev_word[i]   = operand_a_i[WORD_W-1-i];
        assign shift_right_rev_word[i] = shift_right_word[WORD_W-1-i];
    end

    assign shift_in      = shift_left ? operand_a_rev : operand_a_i;
    assign shift_in_word = shift_left ? operand_a_rev_word : operand_a_i[WORD_W-1:0];

    // One right shifter each, sign bit only fed in for arithmetic shifts
    assign shift_right      = $unsigned($signed({shift_arith & shift_in[XLEN-1], shift_in})
                                        >>> shamt);
    assign shift_right_word = $unsigned($signed({shift_arith & shift_in_word[WORD_W-1],
                                                 shift_in_word}) >>> shamt_word);

    assign shift_result_o      = shift_left ? shift_right_rev : shift_right[XLEN-1:0];
    assign shift_result_word_o = shift_left ? shift_right_rev_word
                                            : shift_right_word[WORD_W-1:0];

    // Zero amount passes operand a straight through, both widths
    a_shift_zero : assert property (@(posedge clk_i) disable iff (rst_i)
        (full_op && shamt == '0) || (word_op && shamt_word == '0) |->
        (full_op ? shift_result_o == operand_a_i
                 : shift_result_word_o == operand_a_i[WORD_W-1:0]));

endmodule

/* alu_compare.sv */
// --------------------
// Less-than compare and branch resolution
// --------------------
`timescale 1ns/1ps

module alu_compare (
    input  logic             clk_i,
    input  logic             rst_i,
    input  alu_pkg::alu_op_e operator_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::xlen_t   operand_b_i,
    input  logic             adder_zero_i,
    output logic             less_o,
    output logic             branch_res_o
);

    import alu_pkg::*;

    logic          sign_ext;
    logic [XLEN:0] cmp_a;
    logic [XLEN:0] cmp_b;

    // Signed forms extend with the sign bit, others with zero
    assign sign_ext = operator_i inside {SLTS, LTS, GES};

    assign cmp_a = {sign_ext & operand_a_i[XLEN-1], operand_a_i};
    assign cmp_b = {sign_ext & operand_b_i[XLEN-1], operand_b_i};

    // One signed compare covers both cases
    assign less_o = $signed(cmp_a) < $signed(cmp_b);

    // --------------------
    // Branch outcome
    // --------------------
    always_comb begin
        case (operator_i)
            EQ:       branch_res_o = adder_zero_i;
            NE:       branch_res_o = ~adder_zero_i;
            LTS, LTU: branch_res_o = less_o;
            GES, GEU: branch_res_o = ~less_o;
            default:  branch_res_o = 1'b1;
        endcase
    end

    // EQ and NE outcome from the adder zero flag matches a direct compare
    a_branch_eq : assert property (@(posedge clk_i) disable iff (rst_i)
        (operator_i inside {EQ, NE}) |->
        (branch_res_o == ((operand_a_i == operand_b_i) ^ (operator_i == NE))));

endmodule

/* alu_result_mux.sv */
// --------------------
// Logic ops, word sign extension and final result select
// --------------------
`timescale 1ns/1ps

module alu_result_mux (
    input  logic             clk_i,
    input  logic             rst_i,
    input  alu_pkg::alu_op_e operator_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::xlen_t   operand_b_i,
    input  alu_pkg::xlen_t   adder_result_i,
    input  alu_pkg::xlen_t   shift_result_i,
    input  alu_pkg::word_t   shift_result_word_i,
    input  logic             less_i,
    output alu_pkg::xlen_t   result_o
);

    import alu_pkg::*;

    xlen_t adder_word_ext;
    xlen_t shift_word_ext;
    xlen_t slt_result;
    logic  slt_op;

    // Word results take their sign from bit 31
    assign adder_word_ext = {{(XLEN - WORD_W){adder_result_i[WORD_W-1]}},
                             adder_result_i[WORD_W-1:0]};
    assign shift_word_ext = {{(XLEN - WORD_W){shift_result_word_i[WORD_W-1]}},
                             shift_result_word_i};

    assign slt_result = {{(XLEN - 1){1'b0}}, less_i};
    assign slt_op     = (operator_i == SLTS) || (operator_i == SLTU);

    // --------------------
    // Result select
    // --------------------
    always_comb begin
        result_o = '0;
        case (operator_i)
            ANDL:             result_o = operand_a_i & operand_b_i;
            ORL:              result_o = operand_a_i | operand_b_i;
            XORL:             result_o = operand_a_i ^ operand_b_i;
            ADD, SUB:         result_o = adder_result_i;
            ADDW, SUBW:       result_o = adder_word_ext;
            SLL, SRL, SRA:    result_o = shift_result_i;
            SLLW, SRLW, SRAW: result_o = shift_word_ext;
            SLTS, SLTU:       result_o = slt_result;
            // Branch-only operators give zero
            default:          result_o = '0;
        endcase
    end

    // Compare result lands in bit 0 only and agrees with a direct compare
    a_slt_result : assert property (@(posedge clk_i) disable iff (rst_i)
        slt_op |-> (result_o[XLEN-1:1] == '0) &&
                   (result_o[0] == ((operator_i == SLTS)
                                    ? ($signed(operand_a_i) < $signed(operand_b_i))
                                    : (operand_a_i < operand_b_i))));

endmodule

/* alu.sv */
// --------------------
// 64-bit integer ALU top, combinational datapath
// --------------------
`timescale 1ns/1ps

module alu (
    input  logic             clk_i,
    input  logic             rst_i,
    input  alu_pkg::alu_op_e operator_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::xlen_t   operand_b_i,
    output alu_pkg::xlen_t   result_o,
    output logic             branch_res_o
);

    import alu_pkg::*;

    xlen_t adder_result;
    logic  adder_zero;
    xlen_t shift_result;
    word_t shift_result_word;
    logic  less;

    alu_adder i_alu_adder (
        .operator_i     (operator_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .adder_result_o (adder_result),
        .adder_zero_o   (adder_zero)
    );

    alu_shifter i_alu_shifter (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .operator_i          (operator_i),
        .operand_a_i         (operand_a_i),
        .operand_b_i         (operand_b_i),
        .shift_result_o      (shift_result),
        .shift_result_word_o (shift_result_word)
    );

    // Zero flag from the adder feeds EQ/NE
    alu_compare i_alu_compare (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .operator_i   (operator_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .adder_zero_i (adder_zero),
        .less_o       (less),
        .branch_res_o (branch_res_o)
    );

    alu_result_mux i_alu_result_mux (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .operator_i          (operator_i),
        .operand_a_i         (operand_a_i),
        .operand_b_i         (operand_b_i),
        .adder_result_i      (adder_result),
        .shift_result_i      (shift_result),
        .shift_result_word_i (shift_result_word),
        .less_i              (less),
        .result_o            (result_o)
    );

endmodule

/* tb_alu.sv */
// --------------------
// Testbench for the 64-bit ALU, replays golden vectors
// --------------------
`timescale 1ns/1ps

module tb_alu;

    import alu_pkg::*;

    localparam int MAX_LINES     = 256;
    localparam int RESET_TIMEOUT = 20;
    localparam int EDGE_TIMEOUT  = 4;

    logic    clk;
    logic    rst;
    alu_op_e operator;
    xlen_t   operand_a;
    xlen_t   operand_b;
    xlen_t   result;
    logic    branch_res;

    alu i_alu (
        .clk_i        (clk),
        .rst_i        (rst),
        .operator_i   (operator),
        .operand_a_i  (operand_a),
        .operand_b_i  (operand_b),
        .result_o     (result),
        .branch_res_o (branch_res)
    );

    // --------------------
    // Helpers
    // --------------------
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    // Waits until clk reaches the given level, counting clock toggles
    task automatic wait_edge(input logic to_level);
        int waited;
        waited = 0;
        do begin
            @(clk);
            waited++;
            if (waited > EDGE_TIMEOUT)
                stop_with_failure("timed out waiting for a clock edge");
        end while (clk !== to_level);
    endtask

    task automatic check_result(input alu_op_e op, input alu_pkg::xlen_t expected,
                                input alu_pkg::xlen_t actual);
        if (actual !== expected)
            stop_with_failure($sformatf("error at %0t ns: %s result expected %h, actual %h",
                                        $time, op.name(), expected, actual));
    endtask

    task automatic check_branch(input alu_op_e op, input logic expected, input logic actual);
        if (actual !== expected)
            stop_with_failure($sformatf("error at %0t ns: %s branch expected %b, actual %b",
                                        $time, op.name(), expected, actual));
    endtask

    // --------------------
    // Clock and reset
    // --------------------
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst       = 1'b1;
        operator  = ADD;
        operand_a = '0;
        operand_b = '0;
        for (int i = 0; i < 3; i++)
            wait_edge(1'b1);
        rst <= 1'b0;
    end

    // --------------------
    // Vector replay
    // --------------------
    initial begin
        int               fd;
        int               fields;
        int               line_count;
        int               vec_count;
        int               waited;
        logic [31:0]      op_code;
        xlen_t            a_val;
        xlen_t            b_val;
        xlen_t            exp_result;
        logic [31:0]      exp_branch;
        alu_op_e          op;
        logic [8*160-1:0] line;

        line_count = 0;
        vec_count  = 0;
        waited     = 0;

        while (rst !== 1'b0) begin
            wait_edge(1'b1);
            waited++;
            if (waited > RESET_TIMEOUT)
                stop_with_failure("reset was never released");
        end

        fd = $fopen("alu_golden.txt", "r");
        if (fd == 0)
            stop_with_failure("could not open the golden file alu_golden.txt");

        line = '0;
        while ($fgets(line, fd) != 0) begin
            line_count++;
            if (line_count > MAX_LINES)
                stop_with_failure("golden file holds more lines than expected");
            fields = $sscanf(line, "%h %h %h %h %h",
                             op_code, a_val, b_val, exp_result, exp_branch);
            if (fields == 5) begin
                if (op_code > GEU)
                    stop_with_failure("golden file names an unknown operator code");
                op = alu_op_e'(op_code[OP_W-1:0]);
                // Drive on the rising edge, sample at the falling edge
                wait_edge(1'b1);
                operator  <= op;
                operand_a <= a_val;
                operand_b <= b_val;
                wait_edge(1'b0);
                check_result(op, exp_result, result);
                check_branch(op, exp_branch[0], branch_res);
                vec_count++;
            end else if (fields > 0) begin
                stop_with_failure("golden file has a line with missing fields");
            end
            line = '0;
        end
        $fclose(fd);

        if (vec_count == 0) begin
            stop_with_failure("no vectors found in the golden file");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

/* alu_golden.txt */
// op a b result branch, all in hex
// op is the alu_op_e code, branch is the expected branch_res_o bit
// logic and adder
06 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f000f000f000f000 1
05 f0f0f0f0f0f0f0f0 0f0f00000000ffff fffff0f0f0f0ffff 1
04 0123456789abcdef ffffffffffffffff fedcba9876543210 1
00 0000000000000005 0000000000000003 0000000000000008 1
00 ffffffffffffffff 0000000000000001 0000000000000000 1
00 7fffffffffffffff 0000000000000001 8000000000000000 1
00 123456789abcdef0 0fedcba987654321 2222222222222211 1
01 0000000000000008 0000000000000003 0000000000000005 1
01 0000000000000003 0000000000000005 fffffffffffffffe 1
01 0000000000000000 0000000000000001 ffffffffffffffff 1
// word adder
02 000000007fffffff 0000000000000001 ffffffff80000000 1
02 ffffffff00000005 1234567800000003 0000000000000008 1
02 00000000ffffffff 0000000000000001 0000000000000000 1
03 0000000000000003 0000000000000005 fffffffffffffffe 1
03 abcdef0000000010 0000000100000008 0000000000000008 1
03 0000000080000000 0000000000000001 000000007fffffff 1
// shifts
09 0123456789abcdef 0000000000000000 0123456789abcdef 1
09 0123456789abcdef 0000000000000001 02468acf13579bde 1
09 0000000000000001 000000000000003f 8000000000000000 1
09 0000000000000001 ffffffffffffff44 0000000000000010 1
08 8000000000000000 0000000000000001 4000000000000000 1
08 8000000000000000 000000000000003f 0000000000000001 1
07 8000000000000000 0000000000000001 c000000000000000 1
07 8000000000000000 000000000000003f ffffffffffffffff 1
07 f0f0000000000000 0000000000000004 ff0f000000000000 1
07 7000000000000000 ffffffffffffff43 0e00000000000000 1
0c 0000000000000001 000000000000001f ffffffff80000000 1
0c ffffffff00000003 0000000000000020 0000000000000003 1
0c 0000000012345678 0000000000000004 0000000023456780 1
0b 0000000080000000 0000000000000001 0000000040000000 1
0b ffffffff80000000 000000000000001f 0000000000000001 1
0b 00000000fffffff0 0000000000000000 fffffffffffffff0 1
0a 0000000080000000 0000000000000004 fffffffff8000000 1
0a 800000007fffffff 0000000000000001 000000003fffffff 1
0a 0000000080000000 000000000000003f ffffffffffffffff 1
// set-less-than
0d ffffffffffffffff 0000000000000001 0000000000000001 1
0e ffffffffffffffff 0000000000000001 0000000000000000 1
0e 0000000000000001 ffffffffffffffff 0000000000000001 1
0d 0000000000000005 0000000000000005 0000000000000000 1
// branches
0f 0000000000001234 0000000000001234 0000000000000000 1
0f 0000000000001234 0000000000001235 0000000000000000 0
0f 8000000000000000 0000000000000000 0000000000000000 0
10 0000000000001234 0000000000001235 0000000000000000 1
11 ffffffffffffffff 0000000000000001 0000000000000000 1
12 ffffffffffffffff 0000000000000001 0000000000000000 0
12 0000000000000001 ffffffffffffffff 0000000000000000 1
13 ffffffffffffffff 0000000000000001 0000000000000000 0
13 0000000000000005 0000000000000005 0000000000000000 1
14 ffffffffffffffff 0000000000000001 0000000000000000 1
14 0000000000000001 0000000000000002 0000000000000000 0

/* sources.f */
alu_pkg.sv
alu_adder.sv
alu_shifter.sv
alu_compare.sv
alu_result_mux.sv
alu.sv
tb_alu.sv
